/* verilog.f */
rtl/fb_geom_pkg.sv
rtl/dump_layout_pkg.sv
rtl/char_if.sv
rtl/glyph_if.sv
rtl/field_sequencer.sv
rtl/glyph_lookup.sv
rtl/row_writer.sv
rtl/char_render_top.sv
tests/tb_char_render.sv

/* tests/tb_char_render.sv */
//==================================================
// character renderer testbench
// register source, frame-buffer model, checks
//==================================================
`default_nettype none

module tb_char_render;
	localparam int line_bytes = 80;
	localparam int cell_lines = 10;
	localparam int pass_time = (1 + 16 * 15) * 9 * 8;  // one dump sweep

	logic        clock = 1'b0;
	logic        rst = 1'b1;
	logic [31:0] reg_data;
	logic [3:0]  reg_sel;
	logic [15:0] fb_addr;
	logic [7:0]  fb_data;
	logic        fb_we;

	logic [31:0] regs [0:15];
	logic [7:0]  fb_mem [0:65535];
	logic [3:0]  widx;  // write within current cell
	logic [15:0] last_addr;
	logic [15:0] cell_addr;
	logic [63:0] cell_bmp;
	logic        cell_done;
	logic [15:0] cell_row;
	logic [15:0] cell_col;
	logic        colon_seen = 1'b0;
	logic [63:0] colon_ref;
	int          errs [1:6];

	char_render_top i_dut (
		.clock    (clock),
		.rst      (rst),
		.reg_data (reg_data),
		.reg_sel  (reg_sel),
		.fb_addr  (fb_addr),
		.fb_data  (fb_data),
		.fb_we    (fb_we)
	);

	always #4 clock = ~clock;

	assign reg_data = regs[reg_sel];
	assign cell_row = cell_addr / 16'(line_bytes * cell_lines);
	assign cell_col = cell_addr % 16'(line_bytes);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [63:0] cell_bitmap(input int row, input int col);
		logic [63:0] bits;
		int l;
		bits = '0;
		for (l = 1; l <= 8; l++)
			bits = {bits[55:0], fb_mem[(row * cell_lines + l) * line_bytes + col]};
		return bits;
	endfunction

	// row 6 shows 30313233, so hex digits 3,0,3,1,.. must match cols 12..15
	function automatic logic row6_digits_match();
		logic ok;
		int c;
		int d;
		ok = 1'b1;
		for (c = 3; c <= 10; c++) begin
			d = ((c - 3) % 2 == 0) ? 3 : (c - 3) / 2;
			if (cell_bitmap(6, c) != cell_bitmap(6, 12 + d))
				ok = 1'b0;
		end
		if (cell_bitmap(6, 0) != cell_bitmap(6, 12))  // index high digit '0'
			ok = 1'b0;
		return ok;
	endfunction

	task automatic log_mismatch(input int num, input string msg);
		errs[num]++;
		$display("Mismatch at %0t: %s", $time, msg);
	endtask

	always @(posedge clock) begin
		cell_done <= 1'b0;
		if (rst) begin
			widx <= '0;
		end else if (fb_we) begin
			fb_mem[fb_addr] <= fb_data;
			last_addr <= fb_addr;
			if (widx == 4'd0)
				cell_addr <= fb_addr;
			else
				cell_bmp <= {cell_bmp[55:0], fb_data};
			widx <= (widx == 4'd8) ? 4'd0 : widx + 4'd1;
			cell_done <= (widx == 4'd8);
		end
		if (cell_done && cell_row != 0 && cell_col == 11 && !colon_seen) begin
			colon_seen <= 1'b1;
			colon_ref <= cell_bmp;
		end
	end

	assert property (@(posedge clock) rst |=> !fb_we)
		else log_mismatch(1, "write active during reset");
	assert property (@(posedge clock) $fell(rst) |-> !fb_we && reg_sel == 4'd0 ##1 !fb_we)
		else log_mismatch(1, "write or reg_sel active after reset");
	assert property (@(posedge clock) disable iff (rst) fb_we && widx == 0 |-> fb_data == 8'h00)
		else log_mismatch(2, "first cell byte not blank");
	assert property (@(posedge clock) disable iff (rst)
		fb_we && widx != 0 |-> fb_addr == last_addr + 16'(line_bytes))
		else log_mismatch(2, "address step is not one line");
	assert property (@(posedge clock) disable iff (rst) $fell(fb_we) |-> widx == 4'd0)
		else log_mismatch(2, "write run ended before 9 writes");
	assert property (@(posedge clock) disable iff (rst)
		!$stable(reg_sel) |-> reg_sel == 4'($past(reg_sel) + 4'd1))
		else log_mismatch(3, "reg_sel skipped a register");
	assert property (@(posedge clock) disable iff (rst)
		cell_done && cell_row != 0 && cell_col >= 3 && cell_col <= 10
			|-> cell_row == reg_sel + 1)
		else log_mismatch(3, "hex cell on wrong row");
	assert property (@(posedge clock) disable iff (rst)
		cell_done && cell_row == 6 && cell_col == 15 |-> row6_digits_match())
		else log_mismatch(4, "digit glyphs differ on row 6");
	assert property (@(posedge clock) disable iff (rst)
		cell_done && colon_seen && cell_row != 0 && cell_col == 11 |-> cell_bmp == colon_ref)
		else log_mismatch(5, "colon glyph differs");
	assert property (@(posedge clock) disable iff (rst)
		cell_done && cell_row == 10 && cell_col >= 12
			|-> cell_bmp == (cell_col[0] ? 64'h0 : '1))
		else log_mismatch(6, "0x7F/0x20 cell wrong");
	assert property (@(posedge clock) disable iff (rst)
		cell_done && cell_row == 0 && cell_col == 5 |-> cell_bmp == 64'h0)
		else log_mismatch(6, "title space not blank");

	task automatic wait_cell(input int row, input int col);
		do @(posedge clock); while (!(cell_done && cell_row == row && cell_col == col));
		#2;  // let the assertions of this edge report
	endtask

	task automatic report_test(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, errs[num]);
	endtask

	initial begin
		#(3 * pass_time);
		$display("watchdog expired, the dump did not complete in time");
		$display("TB FAILED");
		$finish;
	end

	initial begin
		logic [31:0] seed;
		int i;
		int total;
		seed = 32'd36;
		for (i = 0; i < 16; i++) begin
			seed = lcg_next(seed);
			regs[i] = seed;
		end
		regs[5] = 32'h30313233;  // "0123"
		regs[9] = 32'h7F207F20;
		repeat (2) @(posedge clock);
		#1 rst = 1'b0;
		repeat (2) @(posedge clock);
		#2 report_test(1, "reset");
		wait_cell(0, 5);
		wait_cell(6, 15);
		report_test(4, "hex vs ascii glyphs");
		wait_cell(10, 15);
		report_test(6, "solid and blank cells");
		wait_cell(16, 15);
		wait_cell(1, 3);  // second sweep reached
		report_test(2, "write runs");
		report_test(3, "register order");
		report_test(5, "colon cells");
		total = 0;
		for (i = 1; i <= 6; i++)
			total += errs[i];
		$display("6 tests run, %0d errors", total);
		if (total == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/char_render_top.sv */
//==================================================
// character renderer top
// register dump -> glyphs -> frame-buffer writes
//==================================================
`default_nettype none

module char_render_top
	import fb_geom_pkg::*;
	import dump_layout_pkg::*;
#(
	parameter int unsigned hori_offset = 0  // lines skipped at top of screen
) (
	input  logic      clock,
	input  logic      rst,
	input  reg_word_t reg_data,
	output reg_sel_t  reg_sel,
	output fb_addr_t  fb_addr,
	output fb_byte_t  fb_data,
	output logic      fb_we
);
	char_if  chars ();
	glyph_if glyphs ();

	field_sequencer i_seq (
		.clock    (clock),
		.rst      (rst),
		.reg_data (reg_data),
		.reg_sel  (reg_sel),
		.chars    (chars.source)
	);

	glyph_lookup i_font (
		.clock  (clock),
		.rst    (rst),
		.chars  (chars.sink),
		.glyphs (glyphs.source)
	);

	row_writer #(
		.hori_offset (hori_offset)
	) i_writer (
		.clock   (clock),
		.rst     (rst),
		.glyphs  (glyphs.sink),
		.fb_addr (fb_addr),
		.fb_data (fb_data),
		.fb_we   (fb_we)
	);

endmodule

`default_nettype wire

/* rtl/row_writer.sv */
//==================================================
// row writer
// one glyph -> blank line plus 8 byte writes
//==================================================
`default_nettype none

module row_writer
	import fb_geom_pkg::*;
#(
	parameter int unsigned hori_offset = 0
) (
	input  logic     clock,
	input  logic     rst,
	glyph_if.sink    glyphs,
	output fb_addr_t fb_addr,
	output fb_byte_t fb_data,
	output logic     fb_we
);
	logic        busy;
	logic [3:0]  line;  // 0 blank, 1..8 glyph rows
	glyph_t      bitmap_q;
	cell_row_t   row_q;
	cell_col_t   col_q;
	logic        fire;
	logic [31:0] addr_full;

	assign glyphs.ready = !busy || (line == 4'(glyph_lines));
	assign fire = glyphs.valid && glyphs.ready;

	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= 1'b0;
			line <= '0;
		end else if (fire) begin
			busy <= 1'b1;
			line <= '0;
		end else if (busy) begin
			if (line == 4'(glyph_lines))
				busy <= 1'b0;
			else
				line <= line + 4'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (fire) begin
			bitmap_q <= glyphs.bitmap;
			row_q <= glyphs.row;
			col_q <= glyphs.col;
		end
	end

	assign addr_full = (32'(row_q) * cell_pitch_lines + 32'(line) + hori_offset)
		* bytes_per_line + 32'(col_q);
	assign fb_addr = addr_full[15:0];
	assign fb_data = (line == 4'd0) ? 8'h00 : bitmap_q[(glyph_lines - line) * 8 +: 8];
	assign fb_we = busy;

	// nine writes per glyph, ending unless the next glyph was taken on the last one
	assert property (@(posedge clock) disable iff (rst)
		glyphs.valid && glyphs.ready |=>
			fb_we [*9] ##1 (!fb_we || $past(glyphs.valid && glyphs.ready)));

endmodule

`default_nettype wire

/* rtl/glyph_lookup.sv */
//==================================================
// glyph lookup
// font ROM, one registered stage per character
//==================================================
`default_nettype none

module glyph_lookup
	import fb_geom_pkg::*;
(
	input logic     clock,
	input logic     rst,
	char_if.sink    chars,
	glyph_if.source glyphs
);
	logic      out_valid;
	glyph_t    out_bitmap;
	cell_row_t out_row;
	cell_col_t out_col;

	function automatic glyph_t font(input char_code_t code);
		case (code)
			8'h20: font = 64'h0000_0000_0000_0000;  // space
			8'h30: font = 64'h3C42_4242_4242_423C;
			8'h31: font = 64'h1838_7818_1818_187E;
			8'h32: font = 64'h3C66_660C_1830_607E;
			8'h33: font = 64'h7C06_067C_0606_067C;
			8'h34: font = 64'h0E16_2646_467E_0606;
			8'h35: font = 64'h7E60_6078_0C06_0C78;
			8'h36: font = 64'h3C40_407C_4242_423C;
			8'h37: font = 64'h7E06_0606_0C18_3060;
			8'h38: font = 64'h3C42_423C_4242_423C;
			8'h39: font = 64'h3C46_4646_3E06_0606;
			8'h3A: font = 64'h0018_1800_0018_1800;  // colon
			8'h41: font = 64'h3C42_4242_7E42_4242;
			8'h42: font = 64'h7C42_467C_4642_427C;
			8'h43: font = 64'h3E60_6060_6060_603E;
			8'h44: font = 64'h7C62_6262_6262_627C;
			8'h45: font = 64'h3E60_607E_6060_603E;
			8'h46: font = 64'h7E60_607E_6060_6060;
			8'h47: font = 64'h3C60_606E_6666_663C;
			8'h4D: font = 64'h4266_5A5A_4242_4242;
			8'h50: font = 64'h7C42_4242_7C60_6060;
			8'h52: font = 64'h3C42_4242_7C58_4C46;
			8'h54: font = 64'h7E18_1818_1818_1818;
			default: font = '1;  // solid block
		endcase
	endfunction

	// take a new char when empty or when the writer drains us
	assign chars.ready = !out_valid || glyphs.ready;

	always_ff @(posedge clock) begin
		if (rst)
			out_valid <= 1'b0;
		else if (chars.valid && chars.ready)
			out_valid <= 1'b1;
		else if (glyphs.ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (chars.valid && chars.ready) begin
			out_bitmap <= font(chars.code);
			out_row <= chars.row;
			out_col <= chars.col;
		end
	end

	assign glyphs.valid = out_valid;
	assign glyphs.bitmap = out_bitmap;
	assign glyphs.row = out_row;
	assign glyphs.col = out_col;

	// a stalled character from the sequencer must not move
	assert property (@(posedge clock) disable iff (rst)
		chars.valid && !chars.ready |=>
			chars.valid && $stable({chars.code, chars.row, chars.col}));

endmodule

`default_nettype wire

/* rtl/field_sequencer.sv */
//==================================================
// field sequencer
// title once, then index/hex/colon/ascii per register
//==================================================
`default_nettype none

module field_sequencer
	import fb_geom_pkg::*;
	import dump_layout_pkg::*;
(
	input  logic      clock,
	input  logic      rst,
	input  reg_word_t reg_data,
	output reg_sel_t  reg_sel,
	char_if.source    chars
);
	localparam logic [2:0] f_start = 3'd0;
	localparam logic [2:0] f_title = 3'd1;
	localparam logic [2:0] f_fetch = 3'd2;
	localparam logic [2:0] f_index = 3'd3;
	localparam logic [2:0] f_hex   = 3'd4;
	localparam logic [2:0] f_colon = 3'd5;
	localparam logic [2:0] f_ascii = 3'd6;

	logic [2:0] field;
	logic [2:0] next_field;
	logic [3:0] char_cnt;
	logic [3:0] field_last;
	reg_word_t  word;
	logic       fire;

	function automatic char_code_t hex_char(input logic [3:0] nib);
		if (nib < 4'd10)
			hex_char = 8'h30 + {4'h0, nib};  // '0'..'9'
		else
			hex_char = 8'h37 + {4'h0, nib};  // 'A'..'F'
	endfunction

	always_comb begin
		case (field)
			f_title: begin
				field_last = 4'(title_len - 1);
				next_field = f_fetch;
			end
			f_index: begin
				field_last = 4'd1;
				next_field = f_hex;
			end
			f_hex: begin
				field_last = 4'd7;
				next_field = f_colon;
			end
			f_colon: begin
				field_last = 4'd0;
				next_field = f_ascii;
			end
			default: begin
				field_last = 4'd3;
				next_field = f_fetch;  // next register
			end
		endcase
	end

	assign chars.valid = (field != f_start) && (field != f_fetch);
	assign fire = chars.valid && chars.ready;

	always_comb begin
		chars.row = (field == f_title) ? 6'd0 : cell_row_t'(reg_sel) + 6'd1;
		case (field)
			f_title: begin
				chars.code = title_text[(title_len - 1 - char_cnt) * 8 +: 8];
				chars.col = cell_col_t'(char_cnt);
			end
			f_index: begin
				chars.code = hex_char(char_cnt[0] ? reg_sel : 4'h0);  // high digit always 0
				chars.col = cell_col_t'(index_col + char_cnt);
			end
			f_hex: begin
				chars.code = hex_char(word[(7 - char_cnt) * 4 +: 4]);
				chars.col = cell_col_t'(hex_col + char_cnt);
			end
			f_colon: begin
				chars.code = 8'h3A;
				chars.col = cell_col_t'(ascii_col);
			end
			default: begin
				chars.code = word[(3 - char_cnt) * 8 +: 8];  // raw byte, msb first
				chars.col = cell_col_t'(ascii_col + 1 + char_cnt);
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			field <= f_start;
			char_cnt <= '0;
			reg_sel <= '0;
		end else begin
			case (field)
				f_start: field <= f_title;
				f_fetch: field <= f_index;
				default: begin
					if (fire) begin
						if (char_cnt == field_last) begin
							char_cnt <= '0;
							field <= next_field;
							if (field == f_ascii)
								reg_sel <= (reg_sel == reg_sel_t'(reg_count - 1)) ? '0 : reg_sel + 4'd1;
						end else begin
							char_cnt <= char_cnt + 4'd1;
						end
					end
				end
			endcase
		end
	end

	// reg_sel has been stable for one cycle here
	always_ff @(posedge clock) begin
		if (field == f_fetch)
			word <= reg_data;
	end

endmodule

`default_nettype wire

/* rtl/glyph_if.sv */
//==================================================
// glyph channel
// 8x8 bitmap and cell position, valid/ready
//==================================================
`default_nettype none

interface glyph_if
	import fb_geom_pkg::*;
();
	logic      valid;
	logic      ready;
	glyph_t    bitmap;
	cell_row_t row;
	cell_col_t col;

	modport source (output valid, bitmap, row, col, input ready);
	modport sink (input valid, bitmap, row, col, output ready);

endinterface

`default_nettype wire

/* rtl/char_if.sv */
//==================================================
// character channel
// code and cell position, valid/ready handshake
//==================================================
`default_nettype none

interface char_if
	import fb_geom_pkg::*;
();
	logic       valid;
	logic       ready;
	char_code_t code;
	cell_row_t  row;
	cell_col_t  col;

	modport source (output valid, code, row, col, input ready);
	modport sink (input valid, code, row, col, output ready);

endinterface

`default_nettype wire

/* rtl/dump_layout_pkg.sv */
//==================================================
// register dump layout
// title line and per-register field positions
//==================================================
`default_nettype none

package dump_layout_pkg;

	localparam int unsigned reg_count = 16;

	typedef logic [3:0]  reg_sel_t;
	typedef logic [31:0] reg_word_t;

	localparam int unsigned index_col = 0;
	localparam int unsigned hex_col   = 3;
	localparam int unsigned ascii_col = 11;  // colon, data bytes follow

	localparam int unsigned title_len = 11;
	localparam logic [87:0] title_text = "GPRMC DATA ";  // first char in top byte

endpackage

`default_nettype wire

/* rtl/fb_geom_pkg.sv */
//==================================================
// frame-buffer geometry
// 640x480 mono buffer, one byte per 8 pixels, 8x8 glyphs
//==================================================
`default_nettype none

package fb_geom_pkg;

	localparam int unsigned bytes_per_line   = 80;  // 640 pixels / 8
	localparam int unsigned cell_pitch_lines = 10;  // blank + 8 glyph lines + gap
	localparam int unsigned glyph_lines      = 8;

	typedef logic [15:0] fb_addr_t;
	typedef logic [7:0]  fb_byte_t;

	// row 1 of the glyph sits in bits 63:56
	typedef logic [63:0] glyph_t;

	typedef logic [7:0]  char_code_t;
	typedef logic [5:0]  cell_row_t;
	typedef logic [6:0]  cell_col_t;

endpackage

`default_nettype wire
